/* sources.f */
+incdir+include
source/tl45_pkg.sv
source/tl45_fetch.sv
source/tl45_decode.sv
source/tl45_regfile.sv
source/tl45_operand.sv
source/tl45_frontend.sv
verification/tl45_frontend_assert.sv
verification/tl45_frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tl45_frontend_tb -f sources.f -o tl45_sim &&
./obj_dir/tl45_sim +verilator+error+limit+100 ||
{ echo "simulation failed" >&2; exit 1; }

/* verification/tl45_frontend_tb.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_frontend_tb import tl45_pkg::*; ();

    localparam int CLK_PERIOD     = 4;
    localparam int N_WORDS        = 64;
    localparam int TIMEOUT_CYCLES = 200;

    logic                  i_clk;
    logic                  i_arst_n;
    logic                  i_stall;
    logic                  i_wb_en;
    logic [`TL45_REGW-1:0] i_wb_reg;
    logic [`TL45_XLEN-1:0] i_wb_data;
    logic [`TL45_XLEN-1:0] i_imem_data;
    logic [`TL45_XLEN-1:0] o_imem_addr;
    logic [`TL45_XLEN-1:0] o_pc;
    tl45_opcode_e          o_opcode;
    logic [`TL45_REGW-1:0] o_dr;
    logic [`TL45_XLEN-1:0] o_opa;
    logic [`TL45_XLEN-1:0] o_opb;
    logic                  o_decode_err;

    logic [`TL45_XLEN-1:0] imem [0:N_WORDS-1];
    logic [31:0]           lfsr = 32'hbeaa;
    tl45_opcode_e          ops [0:13] = '{OP_ADD, OP_SUB, OP_CMP, OP_OR, OP_XOR, OP_AND,
                                          OP_NOT, OP_JMP, OP_CALL, OP_RET, OP_IN, OP_OUT,
                                          OP_LW, OP_SW};

    tl45_frontend UUT (.*);

    assign i_imem_data = imem[o_imem_addr[7:2]];   // Word addressed, wraps at 64

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_word();
        logic [2:0]   kind;
        logic [31:0]  w;
        tl45_opcode_e op;
        kind = 3'(lfsr_bits(3));
        op   = ops[4'(lfsr_bits(4) % 14)];
        w    = {op, 27'(lfsr_bits(27))};
        case (op)
            OP_JMP, OP_CALL, OP_LW, OP_SW: w[26:24] = 3'b001;
            OP_RET: w[26:0] = {3'b000, 4'hF, 20'h00000};
            OP_IN:  w[26:16] = {3'b000, w[23:20], 4'h0};
            OP_OUT: w[26:20] = 7'h00;
            default: begin                          // ALU forms and NOT
                if (!w[26] || op == OP_NOT) begin
                    w[26:24] = 3'b000;
                    w[11:0]  = 12'h000;
                end
            end
        endcase
        if (kind == 3'd0) begin
            w = lfsr_bits(32);                      // Mostly illegal
        end else if (kind == 3'd1) begin
            w = '0;
        end else if (kind == 3'd2) begin
            w = w ^ (32'h1 << (24 + lfsr_bits(2) % 3));   // Break the mode bits
        end
        return w;
    endfunction

    task automatic drive_cycle();
        @(posedge i_clk);
        #1;
        i_stall   = (lfsr_bits(2) == 0);
        i_wb_en   = 1'(lfsr_bits(1));
        i_wb_reg  = (lfsr_bits(2) == 0) ? UUT.dec_sr1 : 4'(lfsr_bits(4));  // Hit the bypass
        i_wb_data = lfsr_bits(32);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        i_arst_n  = 1'b1;
        i_stall   = 1'b0;
        i_wb_en   = 1'b0;
        i_wb_reg  = '0;
        i_wb_data = '0;
        for (int i = 0; i < N_WORDS; i++) begin
            imem[i] = make_word();
        end
        #1 i_arst_n = 1'b0;
        repeat (10) @(posedge i_clk);
        #1 i_arst_n = 1'b1;
        while (o_imem_addr < 32'((N_WORDS + 4) * 4)) begin    // Last word drains
            drive_cycle();
        end
        @(posedge i_clk);
        #1;
        if (UUT.u_assert.fail_cnt != 0) begin
            $display("Finished with errors");
            $fatal(1, "the checker reported a failed assertion");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    initial begin
        wait (UUT.u_assert.fail_cnt != 0);
        $display("Finished with errors");
        $fatal(1, "an assertion in the checker failed");
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Finished with errors");
        $fatal(1, "timeout, the pipeline did not drain within %0d cycles", TIMEOUT_CYCLES);
    end

endmodule

/* verification/tl45_frontend_assert.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_frontend_assert import tl45_pkg::*; (
    input logic                  i_clk,
    input logic                  i_arst_n,
    input logic                  i_stall,
    input logic                  i_wb_en,
    input logic                  o_decode_err,
    input logic [`TL45_REGW-1:0] i_wb_reg,
    input logic [`TL45_REGW-1:0] o_dr,
    input logic [`TL45_OPW-1:0]  o_opcode,
    input logic [`TL45_XLEN-1:0] i_imem_data,
    input logic [`TL45_XLEN-1:0] o_imem_addr,
    input logic [`TL45_XLEN-1:0] i_wb_data,
    input logic [`TL45_XLEN-1:0] o_pc,
    input logic [`TL45_XLEN-1:0] o_opa,
    input logic [`TL45_XLEN-1:0] o_opb
);

    logic [`TL45_XLEN-1:0] sh_word [0:1];          // Fetch and decode buffer words
    logic [`TL45_XLEN-1:0] sh_addr [0:1];
    logic [`TL45_XLEN-1:0] shadow_rf [0:`TL45_NREG-1];
    logic [`TL45_XLEN-1:0] exp_addr;
    logic [`TL45_XLEN-1:0] exp_pc;
    logic [`TL45_OPW-1:0]  exp_op;
    logic [`TL45_REGW-1:0] exp_dr;
    logic [`TL45_XLEN-1:0] exp_opa;
    logic [`TL45_XLEN-1:0] exp_opb;
    logic                  exp_err;
    int                    fail_cnt = 0;

    function automatic logic legal(input logic [`TL45_XLEN-1:0] w);
        logic [2:0] m;
        m = w[26:24];                               // {ri, lh, zs}
        case (w[31:27])
            OP_NOP: return w == '0;
            OP_ADD, OP_SUB, OP_CMP, OP_OR, OP_XOR, OP_AND: begin
                return w[26] || (m == 3'b000 && w[11:0] == 12'h000);
            end
            OP_NOT: return m == 3'b000 && w[11:0] == 12'h000;
            OP_JMP, OP_CALL, OP_LW, OP_SW: return m == 3'b001;
            OP_RET: begin
                return m == 3'b000 && w[23:20] == 4'hF && w[19:16] == 4'h0
                       && w[15:0] == 16'h0000;
            end
            OP_IN:  return m == 3'b000 && w[19:16] == 4'h0;
            OP_OUT: return m == 3'b000 && w[23:20] == 4'h0;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [`TL45_XLEN-1:0] imm_value(input logic [`TL45_XLEN-1:0] w);
        case (w[25:24])
            IMM_ZERO_EXT: return {16'h0000, w[15:0]};
            IMM_SIGN_EXT: return {{16{w[15]}}, w[15:0]};
            default:      return {w[15:0], 16'h0000};      // lh set
        endcase
    endfunction

    // Register value seen by a read on this edge
    function automatic logic [`TL45_XLEN-1:0] reg_read(input logic [`TL45_REGW-1:0] r);
        if (r == '0) return '0;
        if (i_wb_en && i_wb_reg == r) return i_wb_data;
        return shadow_rf[r];
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2; i++) begin
                sh_word[i] <= '0;
                sh_addr[i] <= '0;
            end
            for (int i = 0; i < `TL45_NREG; i++) begin
                shadow_rf[i] <= '0;
            end
            exp_addr <= `TL45_RESET_PC;
            exp_pc   <= '0;
            exp_op   <= '0;
            exp_dr   <= '0;
            exp_opa  <= '0;
            exp_opb  <= '0;
            exp_err  <= 1'b0;
        end else begin
            if (i_wb_en) begin
                shadow_rf[i_wb_reg] <= i_wb_data;
            end
            if (!i_stall) begin
                exp_addr   <= exp_addr + 32'd4;
                sh_word[0] <= i_imem_data;
                sh_addr[0] <= o_imem_addr;
                sh_word[1] <= sh_word[0];
                sh_addr[1] <= sh_addr[0];
                exp_err    <= !legal(sh_word[0]);
                if (legal(sh_word[1])) begin
                    exp_pc  <= sh_addr[1];
                    exp_op  <= sh_word[1][31:27];
                    exp_dr  <= sh_word[1][23:20];
                    exp_opa <= reg_read(sh_word[1][19:16]);
                    exp_opb <= sh_word[1][26] ? imm_value(sh_word[1])
                                              : reg_read(sh_word[1][15:12]);
                end else begin                      // Bubble after an illegal word
                    exp_pc  <= '0;
                    exp_op  <= '0;
                    exp_dr  <= '0;
                    exp_opa <= '0;
                    exp_opb <= '0;
                end
            end
        end
    end

    a_addr: assert property (@(posedge i_clk) disable iff (!i_arst_n) o_imem_addr == exp_addr)
        else begin
            $error("mismatch at %0t: o_imem_addr %h, expected %h", $time,
                   $sampled(o_imem_addr), $sampled(exp_addr));
            fail_cnt++;
        end

    a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_stall |=> $stable(o_pc) && $stable(o_opcode) && $stable(o_dr)
            && $stable(o_opa) && $stable(o_opb) && $stable(o_decode_err))
        else begin
            $error("mismatch at %0t: outputs changed during a stall", $time);
            fail_cnt++;
        end

    a_stage: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pc == exp_pc && o_opcode == exp_op && o_dr == exp_dr && o_decode_err == exp_err)
        else begin
            $error("mismatch at %0t: o_pc %h op %h dr %h err %b, expected %h %h %h %b",
                   $time, $sampled(o_pc), $sampled(o_opcode), $sampled(o_dr),
                   $sampled(o_decode_err), $sampled(exp_pc), $sampled(exp_op),
                   $sampled(exp_dr), $sampled(exp_err));
            fail_cnt++;
        end

    a_operands: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_opa == exp_opa && o_opb == exp_opb)
        else begin
            $error("mismatch at %0t: opa %h opb %h, expected %h %h", $time, $sampled(o_opa),
                   $sampled(o_opb), $sampled(exp_opa), $sampled(exp_opb));
            fail_cnt++;
        end

endmodule

bind tl45_frontend tl45_frontend_assert u_assert (.*);

/* source/tl45_frontend.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_frontend import tl45_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_stall,
    output logic [`TL45_XLEN-1:0]  o_imem_addr,
    input  logic [`TL45_XLEN-1:0]  i_imem_data,
    input  logic                   i_wb_en,
    input  logic [`TL45_REGW-1:0]  i_wb_reg,
    input  logic [`TL45_XLEN-1:0]  i_wb_data,
    output logic [`TL45_XLEN-1:0]  o_pc,
    output tl45_opcode_e           o_opcode,
    output logic [`TL45_REGW-1:0]  o_dr,
    output logic [`TL45_XLEN-1:0]  o_opa,
    output logic [`TL45_XLEN-1:0]  o_opb,
    output logic                   o_decode_err
);

    logic [`TL45_XLEN-1:0] fetch_pc;
    logic [`TL45_XLEN-1:0] fetch_inst;
    logic [`TL45_XLEN-1:0] dec_pc;
    tl45_opcode_e          dec_opcode;
    logic                  dec_ri;
    logic [`TL45_REGW-1:0] dec_dr;
    logic [`TL45_REGW-1:0] dec_sr1;
    logic [`TL45_REGW-1:0] dec_sr2;
    logic [`TL45_XLEN-1:0] dec_imm;
    logic [`TL45_XLEN-1:0] rf_rdata_a;
    logic [`TL45_XLEN-1:0] rf_rdata_b;

    tl45_fetch u_fetch (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_stall     (i_stall),
        .i_imem_data (i_imem_data),
        .o_imem_addr (o_imem_addr),
        .o_pc        (fetch_pc),
        .o_inst      (fetch_inst)
    );

    tl45_decode u_decode (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_stall      (i_stall),
        .i_pc         (fetch_pc),
        .i_inst       (fetch_inst),
        .o_pc         (dec_pc),
        .o_opcode     (dec_opcode),
        .o_ri         (dec_ri),
        .o_dr         (dec_dr),
        .o_sr1        (dec_sr1),
        .o_sr2        (dec_sr2),
        .o_imm        (dec_imm),
        .o_decode_err (o_decode_err)    // Error pulse straight out
    );

    tl45_regfile u_regfile (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_we      (i_wb_en),
        .i_waddr   (i_wb_reg),
        .i_wdata   (i_wb_data),
        .i_raddr_a (dec_sr1),
        .i_raddr_b (dec_sr2),
        .o_rdata_a (rf_rdata_a),
        .o_rdata_b (rf_rdata_b)
    );

    tl45_operand u_operand (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_stall   (i_stall),
        .i_pc      (dec_pc),
        .i_opcode  (dec_opcode),
        .i_ri      (dec_ri),
        .i_dr      (dec_dr),
        .i_imm     (dec_imm),
        .i_rdata_a (rf_rdata_a),
        .i_rdata_b (rf_rdata_b),
        .o_pc      (o_pc),
        .o_opcode  (o_opcode),
        .o_dr      (o_dr),
        .o_opa     (o_opa),
        .o_opb     (o_opb)
    );

endmodule

/* source/tl45_operand.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_operand import tl45_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_stall,
    input  logic [`TL45_XLEN-1:0]  i_pc,
    input  tl45_opcode_e           i_opcode,
    input  logic                   i_ri,
    input  logic [`TL45_REGW-1:0]  i_dr,
    input  logic [`TL45_XLEN-1:0]  i_imm,
    input  logic [`TL45_XLEN-1:0]  i_rdata_a,
    input  logic [`TL45_XLEN-1:0]  i_rdata_b,
    output logic [`TL45_XLEN-1:0]  o_pc,
    output tl45_opcode_e           o_opcode,
    output logic [`TL45_REGW-1:0]  o_dr,
    output logic [`TL45_XLEN-1:0]  o_opa,
    output logic [`TL45_XLEN-1:0]  o_opb
);

    logic [`TL45_XLEN-1:0] opb_sel;

    // Second operand is the immediate for ri forms
    assign opb_sel = i_ri ? i_imm : i_rdata_b;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc     <= '0;
            o_opcode <= OP_NOP;
            o_dr     <= '0;
            o_opa    <= '0;
            o_opb    <= '0;
        end else if (!i_stall) begin
            o_pc     <= i_pc;
            o_opcode <= i_opcode;
            o_dr     <= i_dr;
            o_opa    <= i_rdata_a;          // sr1 value
            o_opb    <= opb_sel;
        end
    end

endmodule

/* source/tl45_regfile.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_regfile (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_we,
    input  logic [`TL45_REGW-1:0]  i_waddr,
    input  logic [`TL45_XLEN-1:0]  i_wdata,
    input  logic [`TL45_REGW-1:0]  i_raddr_a,
    input  logic [`TL45_REGW-1:0]  i_raddr_b,
    output logic [`TL45_XLEN-1:0]  o_rdata_a,
    output logic [`TL45_XLEN-1:0]  o_rdata_b
);

    logic [`TL45_XLEN-1:0] regs [0:`TL45_NREG-1];
    logic                  wr_live;

    assign wr_live = i_we && (i_waddr != '0);   // r0 never written

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `TL45_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Same-cycle write bypass
    assign o_rdata_a = (i_raddr_a == '0) ? '0 :
                       (wr_live && i_waddr == i_raddr_a) ? i_wdata : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 :
                       (wr_live && i_waddr == i_raddr_b) ? i_wdata : regs[i_raddr_b];

endmodule

/* source/tl45_decode.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_decode import tl45_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_stall,
    input  logic [`TL45_XLEN-1:0]  i_pc,
    input  logic [`TL45_XLEN-1:0]  i_inst,
    output logic [`TL45_XLEN-1:0]  o_pc,
    output tl45_opcode_e           o_opcode,
    output logic                   o_ri,
    output logic [`TL45_REGW-1:0]  o_dr,
    output logic [`TL45_REGW-1:0]  o_sr1,
    output logic [`TL45_REGW-1:0]  o_sr2,
    output logic [`TL45_XLEN-1:0]  o_imm,
    output logic                   o_decode_err
);

    logic [`TL45_OPW-1:0]   opcode;
    logic                   ri;
    logic                   lh;
    logic                   zs;
    logic [`TL45_REGW-1:0]  dr;
    logic [`TL45_REGW-1:0]  sr1;
    logic [`TL45_REGW-1:0]  sr2;
    logic [15:0]            imm;
    logic [11:0]            low_imm;
    logic [2:0]             mode;
    tl45_immmode_e          imm_mode;
    logic [`TL45_XLEN-1:0]  resolved_imm;
    logic                   decode_err;

    assign {opcode, ri, lh, zs, dr, sr1, imm} = i_inst;
    assign sr2     = i_inst[15:12];
    assign low_imm = i_inst[11:0];         // Bits clear of sr2
    assign mode    = {ri, lh, zs};

    assign imm_mode = lh ? IMM_HIGH : (zs ? IMM_SIGN_EXT : IMM_ZERO_EXT);

    always_comb begin
        case (imm_mode)
            IMM_ZERO_EXT: resolved_imm = {16'h0000, imm};
            IMM_SIGN_EXT: resolved_imm = {{16{imm[15]}}, imm};
            default:      resolved_imm = {imm, 16'h0000};
        endcase
    end

    // Legality check per opcode
    always_comb begin
        case (opcode)
            OP_NOP: decode_err = (i_inst != '0);
            OP_ADD, OP_SUB, OP_CMP, OP_OR, OP_XOR, OP_AND: begin
                decode_err = !ri && ((mode != 3'b000) || (low_imm != '0));
            end
            OP_NOT: decode_err = (mode != 3'b000) || (low_imm != '0);
            OP_JMP, OP_CALL, OP_LW, OP_SW: begin
                decode_err = (mode != 3'b001);
            end
            OP_RET: begin
                decode_err = (mode != 3'b000) || (dr != 4'hF)
                             || (sr1 != '0) || (imm != '0);
            end
            OP_IN:  decode_err = (mode != 3'b000) || (sr1 != '0);
            OP_OUT: decode_err = (mode != 3'b000) || (dr != '0);
            default: decode_err = 1'b1;
        endcase
    end

    // Decode buffer, illegal words become a bubble
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc         <= '0;
            o_opcode     <= OP_NOP;
            o_ri         <= 1'b0;
            o_dr         <= '0;
            o_sr1        <= '0;
            o_sr2        <= '0;
            o_imm        <= '0;
            o_decode_err <= 1'b0;
        end else if (!i_stall) begin
            o_decode_err <= decode_err;
            if (decode_err) begin
                o_pc     <= '0;
                o_opcode <= OP_NOP;
                o_ri     <= 1'b0;
                o_dr     <= '0;
                o_sr1    <= '0;
                o_sr2    <= '0;
                o_imm    <= '0;
            end else begin
                o_pc     <= i_pc;
                o_opcode <= tl45_opcode_e'(opcode);
                o_ri     <= ri;
                o_dr     <= dr;
                o_sr1    <= sr1;
                o_sr2    <= ri ? '0 : sr2;
                o_imm    <= ri ? resolved_imm : '0;
            end
        end
    end

endmodule

/* source/tl45_fetch.sv */
`timescale 1ns/1ps
`include "tl45_macros.svh"

module tl45_fetch (
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_stall,
    input  logic [`TL45_XLEN-1:0]  i_imem_data,
    output logic [`TL45_XLEN-1:0]  o_imem_addr,
    output logic [`TL45_XLEN-1:0]  o_pc,
    output logic [`TL45_XLEN-1:0]  o_inst
);

    logic [`TL45_XLEN-1:0] pc;

    assign o_imem_addr = pc;

    // Program counter, one word per cycle
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc <= `TL45_RESET_PC;
        end else if (!i_stall) begin
            pc <= pc + `TL45_XLEN'd4;
        end
    end

    // Fetch buffer
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc   <= '0;
            o_inst <= '0;                   // NOP
        end else if (!i_stall) begin
            o_pc   <= pc;
            o_inst <= i_imem_data;
        end
    end

endmodule

/* source/tl45_pkg.sv */
`include "tl45_macros.svh"

package tl45_pkg;

    typedef enum logic [`TL45_OPW-1:0] {
        OP_NOP  = 5'h00,
        OP_ADD  = 5'h01,
        OP_SUB  = 5'h02,
        OP_CMP  = 5'h05,
        OP_OR   = 5'h06,
        OP_XOR  = 5'h07,
        OP_AND  = 5'h08,
        OP_NOT  = 5'h09,
        OP_JMP  = 5'h0C,
        OP_CALL = 5'h0D,
        OP_RET  = 5'h0E,
        OP_IN   = 5'h10,
        OP_OUT  = 5'h11,
        OP_LW   = 5'h14,
        OP_SW   = 5'h15
    } tl45_opcode_e;

    // Immediate handling, from the lh and zs bits
    // lh set wins over zs, so 2'b11 also means high half
    typedef enum logic [1:0] {
        IMM_ZERO_EXT = 2'b00,
        IMM_SIGN_EXT = 2'b01,
        IMM_HIGH     = 2'b10
    } tl45_immmode_e;

endpackage

/* include/tl45_macros.svh */
`ifndef TL45_MACROS_SVH
`define TL45_MACROS_SVH

// Word and address width
`define TL45_XLEN 32

`define TL45_NREG 16
`define TL45_REGW 4

`define TL45_OPW 5

// First fetch address
`define TL45_RESET_PC 32'h0000_0000

`endif
